// ==== hw/colmix_pkg.sv ====
// ==================================================
// types shared by the colour mixer pipeline
// mix_pixel_t is the stage 1 result, 10 bits packed
// palette width default only; top level may override
// ==================================================

package colmix_pkg;

    // winning layer after priority resolution
    typedef enum logic [1:0] {
        LYR_SCR1 = 2'd0,  // scroll plane 1
        LYR_SCR2 = 2'd1,  // scroll plane 2
        LYR_OBJ  = 2'd2,  // sprite plane
        LYR_BG   = 2'd3   // background / out of window
    } layer_e;

    // stage 1 output, one per pixel tick
    typedef struct packed {
        layer_e     lyr;    // layer that won
        logic [3:0] col;    // palette bank
        logic [2:0] pxl;    // colour index
        logic       blank;  // outside visible area
    } mix_pixel_t;

    // final pixel, 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    // mono shade table, 32 entries
    localparam int MONO_AW = 5;

    // colour palette address width, 256 entries by default
    localparam int PAL_AW_DEF = 8;

    // reset value of the stage 1 register: blanked background
    localparam mix_pixel_t MIX_RST = '{
        lyr:   LYR_BG,
        col:   4'd0,
        pxl:   3'd0,
        blank: 1'b1
    };

endpackage

// ==== hw/layer_priority.sv ====
// ==================================================
// stage 1, inputs sampled only when pxl_cen is high
// scroll pixel {bank[3:0], idx[1:0]}, idx 0 clear
// sprite pixel {prio[1:0], bank, idx}, prio 0 clear
// ==================================================
`timescale 1ns/1ps

module layer_priority (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  logic                   scr_order,  // 1: scroll 2 in front
    input  logic                   oow,        // outside of window
    input  logic [2:0]             oowc,       // window colour index
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  logic [5:0]             scr1_pxl,
    input  logic [5:0]             scr2_pxl,
    input  logic [7:0]             obj_pxl,
    output colmix_pkg::mix_pixel_t mix
);
    import colmix_pkg::*;

    logic [5:0] front_pxl;
    logic [5:0] back_pxl;
    layer_e     front_lyr;
    layer_e     back_lyr;
    logic       front_op;
    logic       back_op;
    logic [1:0] obj_prio;
    logic       obj_op;
    mix_pixel_t nxt;

    // front/back plane swap
    assign front_pxl = scr_order ? scr2_pxl : scr1_pxl;
    assign back_pxl  = scr_order ? scr1_pxl : scr2_pxl;
    assign front_lyr = scr_order ? LYR_SCR2 : LYR_SCR1;
    assign back_lyr  = scr_order ? LYR_SCR1 : LYR_SCR2;

    assign front_op = |front_pxl[1:0];  // index 0 is transparent
    assign back_op  = |back_pxl[1:0];

    assign obj_prio = obj_pxl[7:6];
    assign obj_op   = (|obj_pxl[1:0]) && (|obj_prio);

    // painter's order, lowest layer first, later ones overwrite
    always_comb begin
        nxt       = MIX_RST;
        // background, window colour when outside
        nxt.lyr   = LYR_BG;
        nxt.pxl   = oow ? oowc : 3'd0;
        nxt.col   = {2'b11, oow, nxt.pxl[2]};
        // sprite behind both planes
        if (obj_op && obj_prio == 2'd1) begin
            nxt.lyr = LYR_OBJ;
            nxt.col = obj_pxl[5:2];
            nxt.pxl = {1'b0, obj_pxl[1:0]};
        end
        if (back_op) begin
            nxt.lyr = back_lyr;
            nxt.col = back_pxl[5:2];
            nxt.pxl = {1'b0, back_pxl[1:0]};
        end
        // sprite between the planes
        if (obj_op && obj_prio == 2'd2) begin
            nxt.lyr = LYR_OBJ;
            nxt.col = obj_pxl[5:2];
            nxt.pxl = {1'b0, obj_pxl[1:0]};
        end
        if (front_op) begin
            nxt.lyr = front_lyr;
            nxt.col = front_pxl[5:2];
            nxt.pxl = {1'b0, front_pxl[1:0]};
        end
        // sprite on top of everything
        if (obj_op && obj_prio == 2'd3) begin
            nxt.lyr = LYR_OBJ;
            nxt.col = obj_pxl[5:2];
            nxt.pxl = {1'b0, obj_pxl[1:0]};
        end
        nxt.blank = ~(lhbl & lvbl);  // either blanking active
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mix <= MIX_RST;  // starts blanked
        end else if (pxl_cen) begin
            mix <= nxt;
        end
    end

endmodule

// ==== hw/mono_palette.sv ====
// ==================================================
// 32 x 4 bit shade table, cleared by reset
// shade sits in the low nibble of byte 0 only
// lookup and cpu readback both one clock late
// ==================================================
`timescale 1ns/1ps

module mono_palette (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [4:0]             cpu_addr,
    input  logic [3:0]             cpu_wdata,
    input  logic                   we_lo,     // low byte enable
    input  logic                   pal_cs,
    input  logic                   lcd_neg,   // invert shades
    input  colmix_pkg::mix_pixel_t mix,
    output logic [3:0]             cpu_rdata,
    output logic [3:0]             shade
);
    import colmix_pkg::*;

    logic [3:0]         shd_mem [2**MONO_AW];
    logic [MONO_AW-1:0] vid_idx;

    // index: layer, bank lsb, low two index bits
    assign vid_idx = {mix.lyr, mix.col[0], mix.pxl[1:0]};

    // register file, small enough for flops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**MONO_AW; i++) begin
                shd_mem[i] <= 4'd0;
            end
        end else if (pal_cs && we_lo) begin
            shd_mem[cpu_addr] <= cpu_wdata;
        end
    end

    // video lookup, every clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shade <= 4'd0;
        end else begin
            shade <= lcd_neg ? ~shd_mem[vid_idx] : shd_mem[vid_idx];
        end
    end

    // cpu readback, old value on a same-clock write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_rdata <= 4'd0;
        end else begin
            cpu_rdata <= shd_mem[cpu_addr];
        end
    end

endmodule

// ==== hw/color_palette_ram.sv ====
// ==================================================
// true dual port palette, port A cpu, port B video
// contents are not initialised, write before use
// same address read/write returns the old word
// ==================================================
`timescale 1ns/1ps

module color_palette_ram #(
    parameter int pal_aw = 8
) (
    input  logic              clk,
    input  logic [pal_aw-1:0] cpu_addr,
    input  logic [15:0]       cpu_wdata,
    input  logic [1:0]        we,         // byte enables
    input  logic              palrgb_cs,
    input  logic [pal_aw-1:0] vid_addr,
    output logic [15:0]       cpu_q,
    output logic [15:0]       vid_q
);

    logic [15:0] mem [2**pal_aw];
    logic [1:0]  bwe;

    // writes only while selected, byte access allowed
    assign bwe = we & {2{palrgb_cs}};

    // port A, cpu side
    always_ff @(posedge clk) begin
        if (bwe[0]) begin
            mem[cpu_addr][7:0] <= cpu_wdata[7:0];
        end
        if (bwe[1]) begin
            mem[cpu_addr][15:8] <= cpu_wdata[15:8];
        end
        cpu_q <= mem[cpu_addr];  // read before write
    end

    // port B, video side, read only
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];
    end

endmodule

// ==== hw/pixel_output.sv ====
// ==================================================
// stage 3, final rgb register
// mode and lcd_neg must be held stable by the user
// palette word: r in 3:0, b in 7:4, g in 11:8
// ==================================================
`timescale 1ns/1ps

module pixel_output (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mode,   // 1: monochrome
    input  colmix_pkg::mix_pixel_t mix,
    input  logic [3:0]             shade,
    input  logic [15:0]            pal_q,  // top nibble not used
    output colmix_pkg::rgb444_t    rgb
);
    import colmix_pkg::*;

    logic    blank_d;  // blank aligned with lookups
    rgb444_t pal_rgb;
    rgb444_t nxt_rgb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blank_d <= 1'b1;
        end else begin
            blank_d <= mix.blank;
        end
    end

    // unpack the odd channel order of the palette word
    assign pal_rgb.r = pal_q[3:0];
    assign pal_rgb.b = pal_q[7:4];
    assign pal_rgb.g = pal_q[11:8];

    always_comb begin
        if (mode) begin
            nxt_rgb = '{r: shade, g: shade, b: shade};  // grey
        end else begin
            nxt_rgb = pal_rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (blank_d) begin
            rgb <= '0;  // black outside visible area
        end else begin
            rgb <= nxt_rgb;
        end
    end

endmodule

// ==== hw/color_mixer.sv ====
// ==================================================
// colour mixer top, pixel latency 2 clocks
// cpu readback 2 clocks after address and select
// palette address is 8 bits, pal_aw must be <= 8
// ==================================================
`timescale 1ns/1ps

module color_mixer #(
    parameter int pal_aw = colmix_pkg::PAL_AW_DEF
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  logic        mode,
    input  logic        lcd_neg,
    input  logic        scr_order,
    input  logic        oow,
    input  logic [2:0]  oowc,
    input  logic        lhbl,
    input  logic        lvbl,
    input  logic [5:0]  scr1_pxl,
    input  logic [5:0]  scr2_pxl,
    input  logic [7:0]  obj_pxl,
    input  logic [7:0]  cpu_addr,   // word address
    input  logic [15:0] cpu_wdata,
    input  logic [1:0]  we,
    input  logic        pal_cs,     // mono table
    input  logic        palrgb_cs,  // colour ram
    output logic [15:0] cpu_rdata,
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue
);
    import colmix_pkg::*;

    mix_pixel_t mix_s1;
    logic [7:0] vid_addr;
    logic [3:0] mono_shade;
    logic [3:0] mono_q;
    logic [15:0] pal_q;
    logic [15:0] cpal_q;
    logic       rgb_sel;    // palrgb_cs one clock late
    rgb444_t    rgb;

    layer_priority u_prio (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen),
        .scr_order(scr_order), .oow(oow), .oowc(oowc),
        .lhbl(lhbl), .lvbl(lvbl),
        .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl), .obj_pxl(obj_pxl),
        .mix(mix_s1)
    );

    mono_palette u_mono (
        .clk(clk), .rst_n(rst_n),
        .cpu_addr(cpu_addr[MONO_AW-1:0]), .cpu_wdata(cpu_wdata[3:0]),
        .we_lo(we[0]), .pal_cs(pal_cs), .lcd_neg(lcd_neg),
        .mix(mix_s1), .cpu_rdata(mono_q), .shade(mono_shade)
    );

    // layer, bank, low two index bits
    assign vid_addr = {mix_s1.lyr, mix_s1.col, mix_s1.pxl[1:0]};

    color_palette_ram #(.pal_aw(pal_aw)) u_cpal (
        .clk(clk),
        .cpu_addr(cpu_addr[pal_aw-1:0]), .cpu_wdata(cpu_wdata),
        .we(we), .palrgb_cs(palrgb_cs),
        .vid_addr(vid_addr[pal_aw-1:0]),
        .cpu_q(cpal_q), .vid_q(pal_q)
    );

    pixel_output u_out (
        .clk(clk), .rst_n(rst_n), .mode(mode), .mix(mix_s1),
        .shade(mono_shade), .pal_q(pal_q), .rgb(rgb)
    );

    assign red   = rgb.r;
    assign green = rgb.g;
    assign blue  = rgb.b;

    // readback mux follows the select of the address clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb_sel   <= 1'b0;
            cpu_rdata <= 16'd0;
        end else begin
            rgb_sel   <= palrgb_cs;
            cpu_rdata <= rgb_sel ? cpal_q : {12'd0, mono_q};  // mono high bits zero
        end
    end

endmodule

// ==== sim/color_mixer_checker.sv ====
// ==================================================
// concurrent checks bound into the colour mixer top
// blank check assumes rst_n high for 3 clocks after
// the pixel edge, mode held stable by the user
// ==================================================
`timescale 1ns/1ps

module color_mixer_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        pxl_cen,
    input logic        mode,
    input logic        lhbl,
    input logic        lvbl,
    input logic [15:0] cpu_rdata,
    input logic [3:0]  red,
    input logic [3:0]  green,
    input logic [3:0]  blue
);

    logic seen_clk = 1'b0;  // no history before the first edge
    int   blank_fails = 0;
    int   grey_fails  = 0;
    int   reset_fails = 0;
    int   fail_cnt;         // summed for the testbench

    assign fail_cnt = blank_fails + grey_fails + reset_fails;

    always @(posedge clk) begin
        seen_clk <= 1'b1;
    end

    // pixel latched while blanking, output register updated 2 clocks on
    blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n && pxl_cen && !(lhbl && lvbl), 3)
        |-> (red == 4'd0 && green == 4'd0 && blue == 4'd0))
    else begin
        blank_fails++;
        $error("blanked pixel produced a visible colour");
    end

    // mono mode drives one shade on all channels
    mono_grey: assert property (@(posedge clk) disable iff (!rst_n)
        $past(mode) |-> (red == green && green == blue))
    else begin
        grey_fails++;
        $error("monochrome output has unequal channels");
    end

    // covers both during reset and the first clock after it
    reset_clear: assert property (@(posedge clk)
        (seen_clk && $past(!rst_n))
        |-> (red == 4'd0 && green == 4'd0 && blue == 4'd0 && cpu_rdata == 16'd0))
    else begin
        reset_fails++;
        $error("outputs not cleared by reset");
    end

endmodule

// ==== sim/tb_color_mixer.sv ====
// ==================================================
// testbench for the colour mixer top level
// every colour ram entry is written before pixels run
// pxl_cen pulses every second clock while pixels flow
// ==================================================
`timescale 1ns/1ps

module tb_color_mixer;
    import colmix_pkg::*;

    localparam int N_BYTE  = 16;   // single byte colour writes
    localparam int N_RAND  = 200;  // colour mode pixels
    localparam int N_BG    = 16;   // all layers clear
    localparam int N_BLANK = 32;
    localparam int N_MONO  = 100;  // per lcd_neg value
    localparam int N_PIX   = N_RAND + N_BG + N_BLANK + 2 * N_MONO;
    localparam int N_ACC   = 256 + N_BYTE + 33 + 2 * N_BYTE + 32;  // writes plus reads
    localparam int TIMEOUT_NS = (N_PIX + N_ACC) * 4 * 4 + 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        pxl_cen;
    logic        mode;
    logic        lcd_neg;
    logic        scr_order;
    logic        oow;
    logic [2:0]  oowc;
    logic        lhbl;
    logic        lvbl;
    logic [5:0]  scr1_pxl;
    logic [5:0]  scr2_pxl;
    logic [7:0]  obj_pxl;
    logic [7:0]  cpu_addr;
    logic [15:0] cpu_wdata;
    logic [1:0]  we;
    logic        pal_cs;
    logic        palrgb_cs;
    logic [15:0] cpu_rdata;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;

    logic [15:0] cpal_shadow [256];  // what the colour ram should hold
    logic [3:0]  mono_shadow [32];
    logic [7:0]  byte_addr [N_BYTE];
    rgb444_t     exp_q [$];          // one entry per pixel in flight
    rgb444_t     exp_rgb;
    logic [2:0]  cen_hist = 3'b000;  // pxl_cen edges, oldest in bit 2
    int          pix_errors = 0;
    int          bus_errors = 0;
    integer      seed = 32'h7db9_7a3b;

    color_mixer #(.pal_aw(PAL_AW_DEF)) i_color_mixer (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .mode(mode), .lcd_neg(lcd_neg),
        .scr_order(scr_order), .oow(oow), .oowc(oowc), .lhbl(lhbl), .lvbl(lvbl),
        .scr1_pxl(scr1_pxl), .scr2_pxl(scr2_pxl), .obj_pxl(obj_pxl),
        .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .we(we), .pal_cs(pal_cs),
        .palrgb_cs(palrgb_cs), .cpu_rdata(cpu_rdata),
        .red(red), .green(green), .blue(blue)
    );

    bind color_mixer color_mixer_checker u_chk (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .mode(mode),
        .lhbl(lhbl), .lvbl(lvbl), .cpu_rdata(cpu_rdata),
        .red(red), .green(green), .blue(blue)
    );

    initial begin
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, pixel pipeline or bus never finished", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

    // winner as {lyr, col, pxl}, top priority tested first
    function automatic logic [8:0] resolve_layer(
        input logic [5:0] s1, input logic [5:0] s2, input logic [7:0] obj,
        input logic order, input logic out_win, input logic [2:0] win_col);
        logic [5:0] front;
        logic [5:0] back;
        layer_e     front_id;
        layer_e     back_id;
        logic       obj_vis;
        logic [2:0] bg_pxl;
        logic [8:0] res;
        front    = order ? s2 : s1;
        back     = order ? s1 : s2;
        front_id = order ? LYR_SCR2 : LYR_SCR1;
        back_id  = order ? LYR_SCR1 : LYR_SCR2;
        obj_vis  = (obj[1:0] != 2'd0) && (obj[7:6] != 2'd0);
        bg_pxl   = out_win ? win_col : 3'd0;
        if (obj_vis && obj[7:6] == 2'd3) begin
            res = {LYR_OBJ, obj[5:2], 1'b0, obj[1:0]};
        end else if (front[1:0] != 2'd0) begin
            res = {front_id, front[5:2], 1'b0, front[1:0]};
        end else if (obj_vis && obj[7:6] == 2'd2) begin
            res = {LYR_OBJ, obj[5:2], 1'b0, obj[1:0]};
        end else if (back[1:0] != 2'd0) begin
            res = {back_id, back[5:2], 1'b0, back[1:0]};
        end else if (obj_vis) begin
            res = {LYR_OBJ, obj[5:2], 1'b0, obj[1:0]};  // priority 1, behind planes
        end else begin
            res = {LYR_BG, 2'b11, out_win, bg_pxl[2], bg_pxl};
        end
        return res;
    endfunction

    // colour seen on the pins for a resolved pixel
    function automatic rgb444_t expected_rgb(input logic [8:0] win, input logic blank);
        logic [7:0]  caddr;
        logic [4:0]  midx;
        logic [15:0] word;
        logic [3:0]  shd;
        rgb444_t     res;
        caddr = {win[8:7], win[6:3], win[1:0]};
        midx  = {win[8:7], win[3], win[1:0]};  // only bank lsb for mono
        word  = cpal_shadow[caddr];
        shd   = lcd_neg ? ~mono_shadow[midx] : mono_shadow[midx];
        if (blank) begin
            res = '0;
        end else if (mode) begin
            res = '{r: shd, g: shd, b: shd};
        end else begin
            res.r = word[3:0];   // red low, blue mid, green high
            res.g = word[11:8];
            res.b = word[7:4];
        end
        return res;
    endfunction

    task automatic bus_write(input logic to_rgb, input logic [7:0] addr,
                             input logic [15:0] data, input logic [1:0] be);
        @(posedge clk);
        #1;
        cpu_addr  = addr;
        cpu_wdata = data;
        we        = be;
        palrgb_cs = to_rgb;
        pal_cs    = !to_rgb;
        @(posedge clk);
        #1;
        we        = 2'b00;
        palrgb_cs = 1'b0;
        pal_cs    = 1'b0;
        if (to_rgb) begin
            if (be[0]) cpal_shadow[addr][7:0] = data[7:0];
            if (be[1]) cpal_shadow[addr][15:8] = data[15:8];
        end else if (be[0]) begin
            mono_shadow[addr[4:0]] = data[3:0];  // upper address bits alias
        end
    endtask

    // data lands on cpu_rdata two clocks after the address
    task automatic bus_read_check(input logic from_rgb, input logic [7:0] addr,
                                  input logic [15:0] exp);
        @(posedge clk);
        #1;
        cpu_addr  = addr;
        we        = 2'b00;
        palrgb_cs = from_rgb;
        pal_cs    = !from_rgb;
        repeat (2) @(posedge clk);
        #1;
        assert (cpu_rdata === exp) else begin
            $display("mismatch cpu_rdata at %h: got %h expected %h", addr, cpu_rdata, exp);
            bus_errors++;
        end
        palrgb_cs = 1'b0;
        pal_cs    = 1'b0;
    endtask

    task automatic send_pixel(input logic [5:0] s1, input logic [5:0] s2, input logic [7:0] obj,
                              input logic order, input logic out_win, input logic [2:0] win_col,
                              input logic hbl, input logic vbl);
        @(posedge clk);
        #1;
        scr1_pxl  = s1;
        scr2_pxl  = s2;
        obj_pxl   = obj;
        scr_order = order;
        oow       = out_win;
        oowc      = win_col;
        lhbl      = hbl;
        lvbl      = vbl;
        pxl_cen   = 1'b1;
        exp_q.push_back(expected_rgb(resolve_layer(s1, s2, obj, order, out_win, win_col),
                                     !(hbl && vbl)));
        @(posedge clk);
        #1;
        pxl_cen = 1'b0;
    endtask

    task automatic random_pixel(input logic blanked);
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = $random(seed);
        r1 = $random(seed);
        // blanked picks lhbl or lvbl low, never both high
        send_pixel(r0[5:0], r0[11:6], r0[19:12], r0[20], r0[21], r0[24:22],
                   blanked ? r1[0] : 1'b1, blanked ? (!r1[0] && r1[1]) : 1'b1);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic set_mode(input logic mono, input logic neg);
        drain();  // mode must not move under a pixel in flight
        @(posedge clk);
        #1;
        mode    = mono;
        lcd_neg = neg;
    endtask

    always @(posedge clk) begin
        cen_hist <= {cen_hist[1:0], pxl_cen && rst_n};
    end

    // pixel from 2 clocks back, stable here until the next edge
    always @(negedge clk) begin
        if (cen_hist[2]) begin
            if (exp_q.size() == 0) begin
                $display("pixel output arrived with no expected value queued");
                pix_errors++;
            end else begin
                exp_rgb = exp_q.pop_front();
                assert (red === exp_rgb.r) else begin
                    $display("mismatch red: got %h expected %h", red, exp_rgb.r);
                    pix_errors++;
                end
                assert (green === exp_rgb.g) else begin
                    $display("mismatch green: got %h expected %h", green, exp_rgb.g);
                    pix_errors++;
                end
                assert (blue === exp_rgb.b) else begin
                    $display("mismatch blue: got %h expected %h", blue, exp_rgb.b);
                    pix_errors++;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        mode      = 1'b0;
        lcd_neg   = 1'b0;
        scr_order = 1'b0;
        oow       = 1'b0;
        oowc      = 3'd0;
        lhbl      = 1'b1;
        lvbl      = 1'b1;
        scr1_pxl  = 6'd0;
        scr2_pxl  = 6'd0;
        obj_pxl   = 8'd0;
        cpu_addr  = 8'd0;
        cpu_wdata = 16'd0;
        we        = 2'b00;
        pal_cs    = 1'b0;
        palrgb_cs = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < 256; i++) begin
            bus_write(1'b1, i[7:0], {i[7:0] ^ 8'ha5, {i[3:0], i[7:4]} ^ 8'h3c}, 2'b11);
        end
        for (int i = 0; i < N_BYTE; i++) begin
            r = $random(seed);
            byte_addr[i] = r[7:0];
            bus_write(1'b1, r[7:0], r[31:16], i[0] ? 2'b10 : 2'b01);
        end
        for (int i = 0; i < N_BYTE; i++) begin
            r = $random(seed);
            bus_read_check(1'b1, byte_addr[i], cpal_shadow[byte_addr[i]]);
            bus_read_check(1'b1, r[7:0], cpal_shadow[r[7:0]]);
        end
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            bus_write(1'b0, {r[18:16], i[4:0]}, r[15:0], 2'b01);  // junk in high bits
        end
        bus_write(1'b0, 8'd3, 16'h000f, 2'b10);  // high enable alone leaves the shade
        for (int i = 0; i < 32; i++) begin
            bus_read_check(1'b0, {3'b000, i[4:0]}, {12'h000, mono_shadow[i]});
        end
        for (int i = 0; i < N_RAND; i++) begin
            random_pixel(1'b0);
        end
        // nothing opaque, walk oow and every oowc
        for (int i = 0; i < N_BG; i++) begin
            r = $random(seed);
            send_pixel({r[3:0], 2'b00}, {r[7:4], 2'b00},
                       i[1] ? {2'b00, r[13:8]} : {r[15:14], r[13:10], 2'b00},
                       r[16], i[0], i[3:1], 1'b1, 1'b1);
        end
        for (int i = 0; i < N_BLANK; i++) begin
            random_pixel(1'b1);
        end
        set_mode(1'b1, 1'b0);
        for (int i = 0; i < N_MONO; i++) begin
            random_pixel(i[2:0] == 3'd7);
        end
        set_mode(1'b1, 1'b1);
        for (int i = 0; i < N_MONO; i++) begin
            random_pixel(i[2:0] == 3'd7);
        end
        drain();
        $display("errors: pixel %0d, bus %0d, checker %0d", pix_errors, bus_errors,
                 i_color_mixer.u_chk.fail_cnt);
        if (pix_errors == 0 && bus_errors == 0 && i_color_mixer.u_chk.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/colmix_pkg.sv
hw/layer_priority.sv
hw/mono_palette.sv
hw/color_palette_ram.sv
hw/pixel_output.sv
hw/color_mixer.sv
sim/color_mixer_checker.sv
sim/tb_color_mixer.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_color_mixer
FILELIST  := verilog.f
RUN_FLAGS := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "run ended early"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
